//--- cam_capture_top.f
cam_pkg.sv
cam_pixel_if.sv
cam_sensor_sync.sv
cam_pixel_assembler.sv
cam_pixel_fifo.sv
cam_mem_writer.sv
cam_capture_top.sv
tb_cam_capture_top_properties.sv
tb_cam_capture_top.sv

//--- Makefile
# Verilator flow for the camera capture testbench
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_cam_capture_top
FILELIST := cam_capture_top.f
OBJ_DIR  := obj_dir
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_cam_capture_top.sv
`timescale 1ns/1ps

module tb_cam_capture_top
    import cam_pkg::*;
();

    localparam logic [31:0] SEED        = 32'h0cc06579;
    localparam int          RAND_FRAMES = 3;
    localparam int          RAND_LINES  = 4;
    localparam int          LINE_BYTES  = 2 * FRAME_W + 1;
    localparam int          STALL_LINES = 2;
    localparam int          STALL_PIX   = 20;
    localparam int          STALL_DELAY = 60;
    // Idle cycles on the memory bus that mark a drained FIFO
    localparam int          QUIET       = 40;

    logic               CLK;
    logic               arst_n;
    logic               capture_en;
    logic               cam_vsync;
    logic               cam_href;
    logic               cam_pclk;
    logic [7:0]         cam_data;
    logic               wr_ack;
    logic               pixel_valid;
    logic [4:0]         red;
    logic [5:0]         green;
    logic [4:0]         blue;
    logic               wr_req;
    logic [ADDR_W-1:0]  wr_addr;
    logic [15:0]        wr_data;
    logic               overflow;

    // Reference model queues, raw word and {addr, word}
    logic [15:0]        stream_q [$];
    logic [ADDR_W+15:0] mem_q [$];
    logic [31:0]        stim_rng;
    logic [31:0]        mem_rng;
    int                 model_row;
    bit                 stall_mode;
    logic               wr_req_d;
    logic               overflow_d;
    int                 errors;
    int                 checks;

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #5 CLK = ~CLK;
        end
    end

    cam_capture_top i_cam_capture_top (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .capture_en  (capture_en),
        .cam_vsync   (cam_vsync),
        .cam_href    (cam_href),
        .cam_pclk    (cam_pclk),
        .cam_data    (cam_data),
        .wr_ack      (wr_ack),
        .pixel_valid (pixel_valid),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .overflow    (overflow)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Bytes times 6 cycles, line and frame gaps, every ack phase at its longest
    function automatic int watchdog_cycles();
        int bytes;
        int stall_pix;
        stall_pix = STALL_LINES * STALL_PIX;
        bytes = (RAND_FRAMES + 1) * RAND_LINES * LINE_BYTES + 2 * LINE_BYTES
              + 2 * (FRAME_W + 3) + 5 * FRAME_H + 2 * stall_pix;
        return bytes * 6 + 100 * 12 + bytes * 7 + stall_pix * 2 * STALL_DELAY + 5000;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("At %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitors
    ////////////////////////////////////////////////////////////
    task automatic check_stream();
        logic [15:0] exp;
        checks++;
        if (stream_q.size() == 0)
        begin
            report_failure("pixel_valid strobe with no pixel expected");
        end
        else
        begin
            exp = stream_q.pop_front();
            // First byte gives red and upper green
            if (red !== exp[15:11])
                report_mismatch("red", 32'(red), 32'(exp[15:11]));
            if (green !== exp[10:5])
                report_mismatch("green", 32'(green), 32'(exp[10:5]));
            if (blue !== exp[4:0])
                report_mismatch("blue", 32'(blue), 32'(exp[4:0]));
        end
    endtask

    task automatic check_write();
        logic [ADDR_W+15:0] got;
        logic [ADDR_W+15:0] exp;
        got = {wr_addr, wr_data};
        checks++;
        // Dropped pixels skipped, order still kept
        while (stall_mode && mem_q.size() > 0 && mem_q[0] != got)
        begin
            void'(mem_q.pop_front());
        end
        if (mem_q.size() == 0)
        begin
            report_failure("memory write with no pixel expected");
        end
        else
        begin
            exp = mem_q.pop_front();
            if (wr_addr !== exp[ADDR_W+15:16])
                report_mismatch("wr_addr", 32'(wr_addr), 32'(exp[ADDR_W+15:16]));
            if (wr_data !== exp[15:0])
                report_mismatch("wr_data", 32'(wr_data), 32'(exp[15:0]));
        end
    endtask

    always @(negedge CLK)
    begin
        if (arst_n)
        begin
            if (pixel_valid)
                check_stream();
            if (wr_req && !wr_req_d)
                check_write();
            if (overflow && !overflow_d && !stall_mode)
                report_failure("overflow raised with short ack delays");
        end
        wr_req_d   = wr_req;
        overflow_d = overflow;
    end

    ////////////////////////////////////////////////////////////
    // Memory responder
    ////////////////////////////////////////////////////////////
    task automatic pick_delay(output int d);
        mem_rng = xorshift(mem_rng);
        d = stall_mode ? STALL_DELAY : int'(mem_rng % 7);
    endtask

    always @(negedge CLK)
    begin : mem_responder
        int delay;
        if (arst_n && wr_req && !wr_ack)
        begin
            pick_delay(delay);
            repeat (delay) @(negedge CLK);
            wr_ack = 1'b1;
            while (wr_req)
            begin
                @(negedge CLK);
            end
            pick_delay(delay);
            repeat (delay) @(negedge CLK);
            wr_ack = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sensor model
    ////////////////////////////////////////////////////////////
    // Data changes with pclk falling, 3 cycles per half period
    task automatic send_byte(input logic [7:0] b);
        cam_pclk = 1'b0;
        cam_data = b;
        repeat (3) @(negedge CLK);
        cam_pclk = 1'b1;
        repeat (3) @(negedge CLK);
    endtask

    task automatic send_frame_start();
        cam_vsync = 1'b1;
        repeat (6) @(negedge CLK);
        cam_vsync = 1'b0;
        repeat (6) @(negedge CLK);
        model_row = 0;
    endtask

    task automatic send_line(input int n_pix, input bit odd_byte);
        logic [7:0] b0;
        logic [7:0] b1;
        cam_href = 1'b1;
        @(negedge CLK);
        for (int col = 0; col < n_pix; col++)
        begin
            stim_rng = xorshift(stim_rng);
            b0 = stim_rng[7:0];
            b1 = stim_rng[15:8];
            // Only pixels inside the window come out
            if (capture_en && col < FRAME_W && model_row < FRAME_H)
            begin
                stream_q.push_back({b0, b1});
                mem_q.push_back({ADDR_W'(model_row * FRAME_W + col), b0, b1});
            end
            send_byte(b0);
            send_byte(b1);
        end
        // Odd leftover byte, never a pixel
        if (odd_byte)
        begin
            stim_rng = xorshift(stim_rng);
            send_byte(stim_rng[7:0]);
        end
        cam_pclk = 1'b0;
        cam_href = 1'b0;
        // Row advances only after a line with pixels
        if (capture_en && n_pix > 0)
            model_row++;
        repeat (4) @(negedge CLK);
    endtask

    task automatic send_random_frame(input int n_lines);
        int n_pix;
        send_frame_start();
        for (int l = 0; l < n_lines; l++)
        begin
            stim_rng = xorshift(stim_rng);
            n_pix = 1 + int'(stim_rng[15:0] % FRAME_W);
            send_line(n_pix, stim_rng[16]);
        end
    endtask

    // Until every expected write is seen or the bus stays idle
    task automatic wait_writes_done();
        int quiet;
        quiet = 0;
        while (mem_q.size() > 0 && quiet < QUIET)
        begin
            @(negedge CLK);
            if (wr_req || wr_ack)
                quiet = 0;
            else
                quiet++;
        end
    endtask

    task automatic finish_frame_check(input string name);
        wait_writes_done();
        if (stream_q.size() != 0)
            report_failure({name, ": expected pixels never streamed"});
        if (!stall_mode && mem_q.size() != 0)
            report_failure({name, ": expected pixels never written to memory"});
        stream_q.delete();
        mem_q.delete();
    endtask

    task automatic check_quiet_outputs();
        checks++;
        if (wr_req !== 1'b0)
            report_mismatch("wr_req", 32'(wr_req), 32'd0);
        if (pixel_valid !== 1'b0)
            report_mismatch("pixel_valid", 32'(pixel_valid), 32'd0);
        if (overflow !== 1'b0)
            report_mismatch("overflow", 32'(overflow), 32'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        errors     = 0;
        checks     = 0;
        stim_rng   = SEED;
        mem_rng    = xorshift(SEED);
        stall_mode = 1'b0;
        model_row  = 0;
        wr_req_d   = 1'b0;
        overflow_d = 1'b0;
        arst_n     = 1'b0;
        capture_en = 1'b1;
        cam_vsync  = 1'b0;
        cam_href   = 1'b0;
        cam_pclk   = 1'b0;
        cam_data   = 8'h00;
        wr_ack     = 1'b0;
        repeat (4) @(negedge CLK);
        check_quiet_outputs();
        arst_n = 1'b1;
        @(negedge CLK);
        check_quiet_outputs();

        // Random lines, odd tails
        for (int f = 0; f < RAND_FRAMES; f++)
        begin
            send_random_frame(RAND_LINES);
            finish_frame_check("random frame");
        end

        // One over-long line, then one row past the frame
        send_frame_start();
        send_line(FRAME_W + 3, 1'b0);
        for (int l = 0; l < FRAME_H; l++)
        begin
            send_line(2, 1'b1);
        end
        finish_frame_check("window clipping");

        // Capture off, bytes still toggling
        capture_en = 1'b0;
        send_random_frame(2);
        finish_frame_check("capture disabled");
        capture_en = 1'b1;

        // Slow memory fills the FIFO
        stall_mode = 1'b1;
        send_frame_start();
        for (int l = 0; l < STALL_LINES; l++)
        begin
            send_line(STALL_PIX, 1'b0);
        end
        finish_frame_check("ack stall");
        if (overflow !== 1'b1)
            report_failure("overflow not raised under a long ack stall");
        send_frame_start();
        if (overflow !== 1'b0)
            report_mismatch("overflow", 32'(overflow), 32'd0);
        stall_mode = 1'b0;

        // Normal traffic again
        send_random_frame(2);
        finish_frame_check("recovery frame");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (watchdog_cycles()) @(posedge CLK);
        $display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles());
        $display("Test failed");
        $finish;
    end

endmodule

//--- tb_cam_capture_top_properties.sv
`timescale 1ns/1ps

module tb_cam_capture_top_properties
    import cam_pkg::*;
(
    input logic              CLK,
    input logic              arst_n,
    input logic              wr_req,
    input logic              wr_ack,
    input logic [ADDR_W-1:0] wr_addr,
    input logic [15:0]       wr_data,
    input logic              pop,
    input logic              empty
);

    ////////////////////////////////////////////////////////////
    // Four-phase handshake
    ////////////////////////////////////////////////////////////

    // New request only once the last ack is gone
    req_after_ack_low: assert property (@(posedge CLK) disable iff (!arst_n)
        $rose(wr_req) |-> !$past(wr_ack))
        else $error("wr_req rose while wr_ack was still high");

    // Word held from request rise until ack fall
    word_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        (wr_req || wr_ack) && $past(wr_req || wr_ack) |-> $stable(wr_addr) && $stable(wr_data))
        else $error("wr_addr or wr_data changed during a handshake");

    // Pop only with data at the head
    pop_not_empty: assert property (@(posedge CLK) disable iff (!arst_n)
        pop |-> !empty)
        else $error("FIFO popped while empty");

endmodule

// Writer ports carry the FIFO pop and empty nets as well
bind cam_mem_writer tb_cam_capture_top_properties i_tb_cam_capture_top_properties (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .wr_req  (wr_req),
    .wr_ack  (wr_ack),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .pop     (pop),
    .empty   (empty)
);

//--- cam_capture_top.sv
`timescale 1ns/1ps

module cam_capture_top
    import cam_pkg::*;
(
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              capture_en,
    input  logic              cam_vsync,
    input  logic              cam_href,
    input  logic              cam_pclk,
    input  logic [7:0]        cam_data,
    input  logic              wr_ack,
    output logic              pixel_valid,
    output logic [4:0]        red,
    output logic [5:0]        green,
    output logic [4:0]        blue,
    output logic              wr_req,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [15:0]       wr_data,
    output logic              overflow
);

    // Sensor events in the CLK domain
    logic              byte_stb;
    logic [7:0]        byte_data;
    logic              href_s;
    logic              line_end;
    logic              frame_start;

    // FIFO head towards the writer
    logic              fifo_pop;
    logic              fifo_empty;
    pixel_word_t       head_data;
    logic [ADDR_W-1:0] head_addr;

    cam_pixel_if pix_bus ();

    ////////////////////////////////////////////////////////////
    // Capture chain
    ////////////////////////////////////////////////////////////
    cam_sensor_sync i_cam_sensor_sync (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .vsync       (cam_vsync),
        .href        (cam_href),
        .pclk        (cam_pclk),
        .data        (cam_data),
        .byte_stb    (byte_stb),
        .byte_data   (byte_data),
        .href_s      (href_s),
        .line_end    (line_end),
        .frame_start (frame_start)
    );

    cam_pixel_assembler i_cam_pixel_assembler (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .capture_en  (capture_en),
        .byte_stb    (byte_stb),
        .byte_data   (byte_data),
        .href_s      (href_s),
        .line_end    (line_end),
        .frame_start (frame_start),
        .pix         (pix_bus.producer)
    );

    // Memory path
    cam_pixel_fifo i_cam_pixel_fifo (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .pix       (pix_bus.consumer),
        .pop       (fifo_pop),
        .empty     (fifo_empty),
        .head_data (head_data),
        .head_addr (head_addr),
        .overflow  (overflow)
    );

    cam_mem_writer i_cam_mem_writer (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .empty     (fifo_empty),
        .head_data (head_data),
        .head_addr (head_addr),
        .wr_ack    (wr_ack),
        .pop       (fifo_pop),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    // Streaming outputs decode the colour fields, never stalled
    assign pixel_valid = pix_bus.valid;
    assign red         = pix_bus.pixel.rgb.red;
    assign green       = pix_bus.pixel.rgb.green;
    assign blue        = pix_bus.pixel.rgb.blue;

endmodule

//--- cam_mem_writer.sv
`timescale 1ns/1ps

module cam_mem_writer
    import cam_pkg::*;
(
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              empty,
    input  pixel_word_t       head_data,
    input  logic [ADDR_W-1:0] head_addr,
    input  logic              wr_ack,
    output logic              pop,
    output logic              wr_req,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [15:0]       wr_data
);

    logic [WR_STATE_W-1:0] state_q;

    // Take the head only when idle
    // A release phase always sits between two requests
    assign pop = (state_q == WR_IDLE) && !empty;

    ////////////////////////////////////////////////////////////
    // Four-phase handshake FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q <= WR_IDLE;
            wr_req  <= 1'b0;
        end
        else
        begin
            case (state_q)
                WR_IDLE:
                begin
                    if (pop)
                    begin
                        wr_req  <= 1'b1;
                        state_q <= WR_REQ;
                    end
                end
                WR_REQ:
                begin
                    // Memory took the word
                    if (wr_ack)
                    begin
                        wr_req  <= 1'b0;
                        state_q <= WR_REL;
                    end
                end
                WR_REL:
                begin
                    // Wait for ack to drop before the next word
                    if (!wr_ack)
                        state_q <= WR_IDLE;
                end
                default:
                begin
                    wr_req  <= 1'b0;
                    state_q <= WR_IDLE;
                end
            endcase
        end
    end

    // Latched word stays put until the handshake completes
    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            wr_addr <= head_addr;
            wr_data <= head_data.raw;
        end
    end

endmodule

//--- cam_pixel_fifo.sv
`timescale 1ns/1ps

module cam_pixel_fifo
    import cam_pkg::*;
(
    input  logic              CLK,
    input  logic              arst_n,
    cam_pixel_if.consumer     pix,
    input  logic              pop,
    output logic              empty,
    output pixel_word_t       head_data,
    output logic [ADDR_W-1:0] head_addr,
    output logic              overflow
);

    // Storage
    pixel_word_t       data_mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] addr_mem [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              full;
    logic              pop_ok;
    logic              push_ok;

    assign empty   = (count_q == '0);
    assign full    = (count_q == CNT_W'(FIFO_DEPTH));
    assign pop_ok  = pop && !empty;
    // A full FIFO still takes a pixel when the head leaves the same cycle
    assign push_ok = pix.valid && (!full || pop_ok);

    // Head entry read straight from the array
    assign head_data = data_mem[rd_ptr_q];
    assign head_addr = addr_mem[rd_ptr_q];

    ////////////////////////////////////////////////////////////
    // Pointers, count and overflow
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            // Pointers wrap naturally
            if (push_ok)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_ok)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Sticky until the next frame
            if (pix.frame_start)
                overflow <= 1'b0;
            else if (pix.valid && !push_ok)
                overflow <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push_ok)
        begin
            data_mem[wr_ptr_q] <= pix.pixel;
            addr_mem[wr_ptr_q] <= pix.addr;
        end
    end

endmodule

//--- cam_pixel_assembler.sv
`timescale 1ns/1ps

module cam_pixel_assembler
    import cam_pkg::*;
(
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 capture_en,
    input  logic                 byte_stb,
    input  logic [7:0]           byte_data,
    input  logic                 href_s,
    input  logic                 line_end,
    input  logic                 frame_start,
    cam_pixel_if.producer        pix
);

    // Byte phase, low while waiting for the first byte
    logic             phase_q;
    // Held first byte (red and upper green)
    logic [7:0]       first_q;
    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    // Set once the current line has produced a pixel
    logic             line_pix_q;
    logic             take_byte;
    logic             in_frame;

    assign take_byte = byte_stb && href_s && capture_en;
    assign in_frame  = (col_q < COL_W'(FRAME_W)) && (row_q < ROW_W'(FRAME_H));

    ////////////////////////////////////////////////////////////
    // Phase FSM and position counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase_q    <= 1'b0;
            col_q      <= '0;
            row_q      <= '0;
            line_pix_q <= 1'b0;
        end
        else if (frame_start)
        begin
            phase_q    <= 1'b0;
            col_q      <= '0;
            row_q      <= '0;
            line_pix_q <= 1'b0;
        end
        else if (line_end)
        begin
            // Leftover odd byte is dropped here
            phase_q    <= 1'b0;
            col_q      <= '0;
            line_pix_q <= 1'b0;
            // Empty lines do not count as rows
            if (line_pix_q && (row_q != ROW_W'(FRAME_H)))
            begin
                row_q <= row_q + 1'b1;
            end
        end
        else if (!href_s || !capture_en)
        begin
            phase_q <= 1'b0;
        end
        else if (byte_stb)
        begin
            phase_q <= ~phase_q;
            if (phase_q)
            begin
                line_pix_q <= 1'b1;
                // Saturate just past the last column
                if (col_q != COL_W'(FRAME_W))
                begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    // Output strobes
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pix.valid       <= 1'b0;
            pix.frame_start <= 1'b0;
        end
        else
        begin
            pix.valid       <= take_byte && phase_q && in_frame && !frame_start;
            pix.frame_start <= frame_start;
        end
    end

    // Payload
    always_ff @(posedge CLK)
    begin
        if (take_byte && !phase_q)
        begin
            first_q <= byte_data;
        end
        if (take_byte && phase_q)
        begin
            pix.pixel.raw <= {first_q, byte_data};
            pix.addr      <= ADDR_W'(row_q) * ADDR_W'(FRAME_W) + ADDR_W'(col_q);
        end
    end

endmodule

//--- cam_sensor_sync.sv
`timescale 1ns/1ps

module cam_sensor_sync
    import cam_pkg::*;
(
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       vsync,
    input  logic       href,
    input  logic       pclk,
    input  logic [7:0] data,
    output logic       byte_stb,
    output logic [7:0] byte_data,
    output logic       href_s,
    output logic       line_end,
    output logic       frame_start
);

    // Synchroniser chains, bit 0 nearest the pins
    logic [SYNC_STAGES-1:0] vsync_q;
    logic [SYNC_STAGES-1:0] href_q;
    logic [SYNC_STAGES-1:0] pclk_q;
    // Data follows the same depth to stay aligned with pclk
    logic [7:0]             data_q [SYNC_STAGES];

    // History flops for edge detection
    logic vsync_h;
    logic href_h;
    logic pclk_h;

    ////////////////////////////////////////////////////////////
    // Resync and edge detection
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vsync_q     <= '0;
            href_q      <= '0;
            pclk_q      <= '0;
            vsync_h     <= 1'b0;
            href_h      <= 1'b0;
            pclk_h      <= 1'b0;
            byte_stb    <= 1'b0;
            href_s      <= 1'b0;
            line_end    <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            vsync_q     <= {vsync_q[SYNC_STAGES-2:0], vsync};
            href_q      <= {href_q[SYNC_STAGES-2:0], href};
            pclk_q      <= {pclk_q[SYNC_STAGES-2:0], pclk};
            vsync_h     <= vsync_q[SYNC_STAGES-1];
            href_h      <= href_q[SYNC_STAGES-1];
            pclk_h      <= pclk_q[SYNC_STAGES-1];
            // Registered pulses, one per detected edge
            byte_stb    <= pclk_q[SYNC_STAGES-1] && !pclk_h;
            line_end    <= !href_q[SYNC_STAGES-1] && href_h;
            frame_start <= vsync_q[SYNC_STAGES-1] && !vsync_h;
            href_s      <= href_q[SYNC_STAGES-1];
        end
    end

    // Data path, sampled with the strobe
    always_ff @(posedge CLK)
    begin
        data_q[0] <= data;
        for (int i = 1; i < SYNC_STAGES; i++)
        begin
            data_q[i] <= data_q[i-1];
        end
        byte_data <= data_q[SYNC_STAGES-1];
    end

endmodule

//--- cam_pixel_if.sv
`timescale 1ns/1ps

interface cam_pixel_if
    import cam_pkg::*;
();

    // One-cycle strobe per assembled pixel
    logic              valid;
    // Pixel word, valid alongside the strobe
    pixel_word_t       pixel;
    // Frame buffer address of that pixel
    logic [ADDR_W-1:0] addr;
    // One-cycle pulse at each new frame
    logic              frame_start;

    // Assembler side
    modport producer (
        output valid,
        output pixel,
        output addr,
        output frame_start
    );

    // FIFO and streaming outputs
    // No back-pressure path exists
    modport consumer (
        input valid,
        input pixel,
        input addr,
        input frame_start
    );

endinterface

//--- cam_pkg.sv
package cam_pkg;

    ////////////////////////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////////////////////////

    // Active window delivered by the sensor
    localparam int FRAME_W = 64;
    localparam int FRAME_H = 48;

    // Counters keep one extra code to saturate just past the window
    localparam int COL_W = $clog2(FRAME_W + 1);
    localparam int ROW_W = $clog2(FRAME_H + 1);

    // Frame buffer word address
    localparam int ADDR_W = 12;

    // Flops per sensor input before edge detection
    localparam int SYNC_STAGES = 2;

    ////////////////////////////////////////////////////////////
    // Pixel FIFO and memory writer
    ////////////////////////////////////////////////////////////

    // Must stay a power of two so the pointers wrap on their own
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = PTR_W + 1;

    // Writer FSM encoding
    localparam int                    WR_STATE_W = 2;
    localparam logic [WR_STATE_W-1:0] WR_IDLE    = 2'd0;
    localparam logic [WR_STATE_W-1:0] WR_REQ     = 2'd1;
    localparam logic [WR_STATE_W-1:0] WR_REL     = 2'd2;

    // RGB565 field layout, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // Same 16 bits seen as the byte pair or as colour fields
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     rgb;
    } pixel_word_t;

endpackage
